/* sim.f */
+incdir+hdl
hdl/seq_pkg.sv
hdl/op_exe_dispatch.sv
hdl/exe_wb_arbiter.sv
hdl/backend_sequencer.sv
dv/tb_backend_sequencer.sv

/* Bender.yml */
package:
  name: backend_sequencer

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/seq_pkg.sv
      - hdl/op_exe_dispatch.sv
      - hdl/exe_wb_arbiter.sv
      - hdl/backend_sequencer.sv
      - target: test
        files:
          - dv/tb_backend_sequencer.sv

/* dv/tb_backend_sequencer.sv */
`timescale 1ns/1ns
`include "seq_macros.svh"

module tb_backend_sequencer import seq_pkg::*; ();

    localparam int N_UOPS      = 600;
    localparam int CYCLE_LIMIT = N_UOPS * 32 + 800;  // 20000 cycles
    localparam logic [31:0] SEED = 32'hf93b133f;

    logic                    clk;
    logic                    arst_n;
    logic [`N_SLOTS-1:0]     issue_valid;
    uop_t                    issue_uop [`N_SLOTS];
    logic [`N_SLOTS-1:0]     issue_ready;
    logic [`N_EXE_UNITS-1:0] exe_valid;
    uop_t                    exe_uop [`N_EXE_UNITS];
    logic [`N_EXE_UNITS-1:0] exe_ready;
    logic [`N_EXE_UNITS-1:0] res_valid;
    exe_res_t                res [`N_EXE_UNITS];
    redirect_t               beu_redirect;
    logic [`N_EXE_UNITS-1:0] res_ready;
    logic [`N_SLOTS-1:0]     wb_valid;
    wb_t                     wb [`N_SLOTS];

    // reference model state
    uop_t                    uops [N_UOPS];
    int                      unit_list [`N_EXE_UNITS][N_UOPS];
    int                      unit_wr [`N_EXE_UNITS];
    int                      unit_rd [`N_EXE_UNITS];
    logic [`N_EXE_UNITS-1:0] model_full;
    int                      head;
    int                      taken;
    logic                    keep_all;   // nothing accepted, show the same slots again
    logic                    keep_head;  // slot 1 left behind, now the head
    int                      cycles;

    backend_sequencer backend_sequencer_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .issue_valid_i  (issue_valid),
        .issue_uop_i    (issue_uop),
        .issue_ready_o  (issue_ready),
        .exe_valid_o    (exe_valid),
        .exe_uop_o      (exe_uop),
        .exe_ready_i    (exe_ready),
        .res_valid_i    (res_valid),
        .res_i          (res),
        .beu_redirect_i (beu_redirect),
        .res_ready_o    (res_ready),
        .wb_valid_o     (wb_valid),
        .wb_o           (wb)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("timeout: the uops did not drain within the cycle limit");
        end
    end

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bits(input string what, input logic [`N_EXE_UNITS-1:0] got,
                              input logic [`N_EXE_UNITS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run("bit vector mismatch");
        end
    endtask

    task automatic check_uop(input string what, input uop_t got, input uop_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run("uop mismatch");
        end
    endtask

    task automatic check_wb(input string what, input wb_t got, input wb_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run("writeback mismatch");
        end
    endtask

    function automatic int unit_of(input exe_unit_t sel);
        int idx;
        idx = 0;
        for (int u = 0; u < `N_EXE_UNITS; u++) begin
            if (sel[u]) begin
                idx = u;
            end
        end
        return idx;
    endfunction

    // writeback priority, highest first
    function automatic int unit_at_rank(input int k);
        case (k)
            0:       return `H_ALU0;
            1:       return `H_ALU1;
            2:       return `H_BEU;
            default: return `H_LSU;
        endcase
    endfunction

    function automatic uop_t make_uop(input int n);
        uop_t u;
        u.inst      = inst_t'($urandom);
        u.rs1_valid = 1'($urandom);
        u.rs1       = reg_idx_t'($urandom);
        u.rs1_value = {$urandom, $urandom};
        u.rs2_valid = 1'($urandom);
        u.rs2       = reg_idx_t'($urandom);
        u.rs2_value = {$urandom, $urandom};
        u.rd        = reg_idx_t'($urandom);
        u.rd_type   = rd_type_t'($urandom);
        u.exe_unit  = exe_unit_t'(1 << ($urandom % `N_EXE_UNITS));
        u.func_code = func_code_t'($urandom);
        u.func3     = func3_t'($urandom);
        u.sid       = sid_t'(n);
        return u;
    endfunction

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic drive_inputs();
        logic v0;
        logic v1;
        int   idx1;
        if (keep_all) begin
            v0 = issue_valid[0];
            v1 = issue_valid[1];
        end else if (keep_head) begin
            v0 = 1'b1;
            v1 = ($urandom % 4) != 0;
        end else begin
            v0 = ($urandom % 4) != 0;
            v1 = ($urandom % 4) != 0;
        end
        v0   = v0 && (head < N_UOPS);
        idx1 = head + int'(v0);  // slot 1 carries the head when slot 0 is empty
        v1   = v1 && (idx1 < N_UOPS);
        issue_valid  = {v1, v0};
        issue_uop[0] = (head < N_UOPS) ? uops[head] : '0;
        issue_uop[1] = (idx1 < N_UOPS) ? uops[idx1] : '0;

        exe_ready = exe_unit_t'($urandom) | exe_unit_t'($urandom);
        res_valid = exe_unit_t'($urandom);
        for (int u = 0; u < `N_EXE_UNITS; u++) begin
            res[u].data = {$urandom, $urandom};
            res[u].rd   = reg_idx_t'($urandom);
            res[u].sid  = sid_t'($urandom);
            res[u].inst = inst_t'($urandom);
        end
        beu_redirect.taken = 1'($urandom);
        beu_redirect.pc    = {$urandom, $urandom};
    endtask

    ////////////////////////////////////////
    // model and compare
    ////////////////////////////////////////
    task automatic check_dispatch();
        logic [`N_EXE_UNITS-1:0] free;
        logic [`N_EXE_UNITS-1:0] load;
        logic                    rdy0;
        logic                    rdy1;
        logic                    acc0;
        logic                    acc1;
        int                      u0;
        int                      u1;
        free = ~model_full | exe_ready;
        u0   = unit_of(issue_uop[0].exe_unit);
        u1   = unit_of(issue_uop[1].exe_unit);
        rdy0 = free[u0];
        rdy1 = free[u1] && (!issue_valid[0] || rdy0) && !(issue_valid[0] && u0 == u1);
        check_bits("issue_ready_o", {2'b00, issue_ready & issue_valid},
                   {2'b00, {rdy1, rdy0} & issue_valid});

        check_bits("exe_valid_o", exe_valid, model_full);
        for (int u = 0; u < `N_EXE_UNITS; u++) begin
            if (model_full[u]) begin
                check_uop($sformatf("exe_uop_o[%0d]", u), exe_uop[u],
                          uops[unit_list[u][unit_rd[u]]]);
                if (exe_ready[u]) begin
                    unit_rd[u]++;
                    taken++;
                end
            end
        end

        acc0 = issue_valid[0] && rdy0;
        acc1 = issue_valid[1] && rdy1;
        load = '0;
        if (acc0) begin
            unit_list[u0][unit_wr[u0]] = head;
            unit_wr[u0]++;
            load[u0] = 1'b1;
        end
        if (acc1) begin
            unit_list[u1][unit_wr[u1]] = head + int'(issue_valid[0]);
            unit_wr[u1]++;
            load[u1] = 1'b1;
        end
        model_full = (model_full & ~exe_ready) | load;
        head       = head + int'(acc0) + int'(acc1);
        keep_all   = (|issue_valid) && !acc0 && !acc1;
        keep_head  = acc0 && issue_valid[1] && !acc1;
    endtask

    task automatic check_writeback();
        int                      hit [`N_SLOTS];
        int                      n;
        int                      u;
        wb_t                     exp_wb [`N_SLOTS];
        logic [`N_EXE_UNITS-1:0] exp_rr;
        logic [`N_SLOTS-1:0]     exp_v;
        n      = 0;
        exp_rr = '0;
        exp_v  = '0;
        for (int k = 0; k < `N_EXE_UNITS; k++) begin
            if (res_valid[unit_at_rank(k)] && n < `N_SLOTS) begin
                hit[n] = unit_at_rank(k);
                n++;
            end
        end
        for (int p = 0; p < `N_SLOTS; p++) begin
            exp_wb[p] = '0;  // empty port shows all zeros
            if (p < n) begin
                u                 = hit[p];
                exp_v[p]          = 1'b1;
                exp_rr[u]         = 1'b1;
                exp_wb[p].data    = res[u].data;
                exp_wb[p].rd      = res[u].rd;
                exp_wb[p].sid     = res[u].sid;
                exp_wb[p].inst    = res[u].inst;
                if (u == `H_BEU) begin
                    exp_wb[p].redirect    = beu_redirect.taken;
                    exp_wb[p].redirect_pc = beu_redirect.pc;
                end
            end
            check_wb($sformatf("wb_o[%0d]", p), wb[p], exp_wb[p]);
        end
        check_bits("res_ready_o", res_ready, exp_rr);
        check_bits("wb_valid_o", {2'b00, wb_valid}, {2'b00, exp_v});
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        arst_n       = 1'b0;
        issue_valid  = '0;
        exe_ready    = '0;
        res_valid    = '0;
        beu_redirect = '0;
        for (int s = 0; s < `N_SLOTS; s++) begin
            issue_uop[s] = '0;
        end
        for (int u = 0; u < `N_EXE_UNITS; u++) begin
            res[u]     = '0;
            unit_wr[u] = 0;
            unit_rd[u] = 0;
        end
        model_full = '0;
        head       = 0;
        taken      = 0;
        keep_all   = 1'b0;
        keep_head  = 1'b0;
        cycles     = 0;
        for (int i = 0; i < N_UOPS; i++) begin
            uops[i] = make_uop(i);
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_bits("exe_valid_o after reset", exe_valid, '0);
        arst_n = 1'b1;

        while (taken < N_UOPS) begin
            drive_inputs();
            #2;
            check_dispatch();
            check_writeback();
            @(negedge clk);
        end

        #2;
        if (head == N_UOPS && model_full == '0 && exe_valid == '0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("uops still in flight after the last one was taken");
        end
    end

endmodule

/* hdl/backend_sequencer.sv */
`timescale 1ns/1ns
`include "seq_macros.svh"

module backend_sequencer import seq_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // issue slots
    input  logic [`N_SLOTS-1:0]     issue_valid_i,
    input  uop_t                    issue_uop_i [`N_SLOTS],
    output logic [`N_SLOTS-1:0]     issue_ready_o,
    // execution units
    output logic [`N_EXE_UNITS-1:0] exe_valid_o,
    output uop_t                    exe_uop_o [`N_EXE_UNITS],
    input  logic [`N_EXE_UNITS-1:0] exe_ready_i,
    // unit results
    input  logic [`N_EXE_UNITS-1:0] res_valid_i,
    input  exe_res_t                res_i [`N_EXE_UNITS],
    input  redirect_t               beu_redirect_i,
    output logic [`N_EXE_UNITS-1:0] res_ready_o,
    // writeback ports
    output logic [`N_SLOTS-1:0]     wb_valid_o,
    output wb_t                     wb_o [`N_SLOTS]
);

    ////////////////////////////////////////
    // issue to execute
    ////////////////////////////////////////
    op_exe_dispatch op_exe_dispatch_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_uop_i   (issue_uop_i),
        .issue_ready_o (issue_ready_o),
        .exe_valid_o   (exe_valid_o),
        .exe_uop_o     (exe_uop_o),
        .exe_ready_i   (exe_ready_i)
    );

    ////////////////////////////////////////
    // execute to writeback
    ////////////////////////////////////////
    exe_wb_arbiter exe_wb_arbiter_i (
        .res_valid_i    (res_valid_i),
        .res_i          (res_i),
        .beu_redirect_i (beu_redirect_i),
        .res_ready_o    (res_ready_o),
        .wb_valid_o     (wb_valid_o),
        .wb_o           (wb_o)
    );

endmodule

/* hdl/exe_wb_arbiter.sv */
`timescale 1ns/1ns
`include "seq_macros.svh"

module exe_wb_arbiter import seq_pkg::*; (
    // result side
    input  logic [`N_EXE_UNITS-1:0] res_valid_i,
    input  exe_res_t                res_i [`N_EXE_UNITS],
    input  redirect_t               beu_redirect_i,
    output logic [`N_EXE_UNITS-1:0] res_ready_o,
    // writeback side, one port per issue slot
    output logic [`N_SLOTS-1:0]     wb_valid_o,
    output wb_t                     wb_o [`N_SLOTS]
);

    // highest priority first
    localparam int unsigned prio_order [`N_EXE_UNITS] = '{`H_ALU0, `H_ALU1, `H_BEU, `H_LSU};

    exe_unit_t grant [`N_SLOTS];

    ////////////////////////////////////////
    // grants
    ////////////////////////////////////////
    always_comb begin : grant_sel
        logic found0;
        logic found1;
        found0   = 1'b0;
        found1   = 1'b0;
        grant[0] = '0;
        grant[1] = '0;
        for (int k = 0; k < `N_EXE_UNITS; k++) begin
            if (res_valid_i[prio_order[k]]) begin
                if (!found0) begin
                    grant[0][prio_order[k]] = 1'b1;
                    found0                  = 1'b1;
                end else if (!found1) begin
                    grant[1][prio_order[k]] = 1'b1;  // second valid only, never a repeat
                    found1                  = 1'b1;
                end
            end
        end
    end

    assign res_ready_o = grant[0] | grant[1];

    ////////////////////////////////////////
    // port assembly
    ////////////////////////////////////////
    always_comb begin : wb_mux
        for (int p = 0; p < `N_SLOTS; p++) begin
            wb_o[p] = '0;
            for (int u = 0; u < `N_EXE_UNITS; u++) begin
                wb_o[p].data = wb_o[p].data | ({`XLEN{grant[p][u]}} & res_i[u].data);
                wb_o[p].rd   = wb_o[p].rd | ({`REG_IDX_W{grant[p][u]}} & res_i[u].rd);
                wb_o[p].sid  = wb_o[p].sid
                             | ({(`SCOREBOARD_SIZE_WIDTH + 1){grant[p][u]}} & res_i[u].sid);
                wb_o[p].inst = wb_o[p].inst | ({`INST_W{grant[p][u]}} & res_i[u].inst);
            end
            // redirect rides with the beu result only
            wb_o[p].redirect    = grant[p][`H_BEU] & beu_redirect_i.taken;
            wb_o[p].redirect_pc = {`XLEN{grant[p][`H_BEU]}} & beu_redirect_i.pc;
            wb_valid_o[p]       = |grant[p];
        end
    end

endmodule

/* hdl/op_exe_dispatch.sv */
`timescale 1ns/1ns
`include "seq_macros.svh"

module op_exe_dispatch import seq_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // issue side
    input  logic [`N_SLOTS-1:0]     issue_valid_i,
    input  uop_t                    issue_uop_i [`N_SLOTS],
    output logic [`N_SLOTS-1:0]     issue_ready_o,
    // execute side
    output logic [`N_EXE_UNITS-1:0] exe_valid_o,
    output uop_t                    exe_uop_o [`N_EXE_UNITS],
    input  logic [`N_EXE_UNITS-1:0] exe_ready_i
);

    exe_unit_t                tgt0;
    exe_unit_t                tgt1;
    logic [`N_EXE_UNITS-1:0]  full_q;
    logic [`N_EXE_UNITS-1:0]  unit_free;
    logic                     same_unit;
    logic                     slot0_clear;
    logic [`N_SLOTS-1:0]      accept;
    exe_unit_t                load0;
    exe_unit_t                load1;
    uop_t                     hold_q [`N_EXE_UNITS];

    ////////////////////////////////////////
    // readiness
    ////////////////////////////////////////
    assign tgt0 = issue_uop_i[0].exe_unit;
    assign tgt1 = issue_uop_i[1].exe_unit;

    // empty, or emptied by the unit this cycle
    assign unit_free = ~full_q | exe_ready_i;

    assign issue_ready_o[0] = |(tgt0 & unit_free);

    // slot 1 never overtakes a waiting slot 0
    assign slot0_clear = ~issue_valid_i[0] | issue_ready_o[0];
    assign same_unit   = issue_valid_i[0] & (|(tgt0 & tgt1));  // one load per unit per cycle

    assign issue_ready_o[1] = (|(tgt1 & unit_free)) & slot0_clear & ~same_unit;

    assign accept = issue_valid_i & issue_ready_o;

    // slot 0 has the register if both point at it
    assign load0 = {`N_EXE_UNITS{accept[0]}} & tgt0;
    assign load1 = {`N_EXE_UNITS{accept[1]}} & tgt1 & ~load0;

    ////////////////////////////////////////
    // holding registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= '0;
        end else begin
            full_q <= load0 | load1 | (full_q & ~exe_ready_i);  // held until taken
        end
    end

    always_ff @(posedge clk_i) begin
        for (int u = 0; u < `N_EXE_UNITS; u++) begin
            if (load0[u]) begin
                hold_q[u] <= issue_uop_i[0];
            end else if (load1[u]) begin
                hold_q[u] <= issue_uop_i[1];
            end
        end
    end

    assign exe_valid_o = full_q;
    assign exe_uop_o   = hold_q;

endmodule

/* hdl/seq_pkg.sv */
`include "seq_macros.svh"

package seq_pkg;

    ////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////
    typedef logic [`XLEN-1:0]                xlen_t;
    typedef logic [`REG_IDX_W-1:0]           reg_idx_t;
    typedef logic [`INST_W-1:0]              inst_t;
    typedef logic [`SCOREBOARD_SIZE_WIDTH:0] sid_t;
    typedef logic [`N_EXE_UNITS-1:0]         exe_unit_t;  // one-hot, see H_* positions
    typedef logic [3:0]                      func_code_t;
    typedef logic [2:0]                      func3_t;
    typedef logic [1:0]                      rd_type_t;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    // decoded micro-op with its operand values
    typedef struct packed {
        inst_t      inst;
        logic       rs1_valid;
        reg_idx_t   rs1;
        xlen_t      rs1_value;
        logic       rs2_valid;
        reg_idx_t   rs2;
        xlen_t      rs2_value;
        reg_idx_t   rd;
        rd_type_t   rd_type;
        exe_unit_t  exe_unit;
        func_code_t func_code;
        func3_t     func3;
        sid_t       sid;
    } uop_t;

    // result of one execution unit
    typedef struct packed {
        xlen_t    data;
        reg_idx_t rd;
        sid_t     sid;
        inst_t    inst;
    } exe_res_t;

    // branch outcome from the beu
    typedef struct packed {
        logic  taken;
        xlen_t pc;
    } redirect_t;

    // one writeback port
    typedef struct packed {
        xlen_t    data;
        reg_idx_t rd;
        sid_t     sid;
        inst_t    inst;
        logic     redirect;
        xlen_t    redirect_pc;
    } wb_t;

endpackage

/* hdl/seq_macros.svh */
`ifndef SEQ_MACROS_SVH
`define SEQ_MACROS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define XLEN 64
`define REG_IDX_W 5
`define INST_W 32
// sid is one bit wider than this
`define SCOREBOARD_SIZE_WIDTH 3

////////////////////////////////////////
// machine shape
////////////////////////////////////////
`define N_EXE_UNITS 4
`define N_SLOTS 2

// bit positions in the one-hot unit field, also the writeback priority order
`define H_ALU0 0
`define H_ALU1 1
`define H_BEU 2
`define H_LSU 3

`endif
